// File: src/game_pkg.sv
package game_pkg;

	//----------------------------------------------------------------------
	// Scroll position widths
	//----------------------------------------------------------------------

	localparam int TILE_POS_W  = 16;	// Level tile position
	localparam int PIXEL_POS_W = 3;		// Pixel offset inside a tile
	localparam int TILE_PIXELS = 8;		// Pixels per tile

	//----------------------------------------------------------------------
	// Timing
	//----------------------------------------------------------------------

	localparam int FRAME_CLOCKS_DEFAULT  = 833_333;		// 60 fps at 50 MHz
	localparam int SECOND_CLOCKS_DEFAULT = 50_000_000;	// One second at 50 MHz
	localparam int FRAME_TIMER_W         = 20;		// Fits a full frame period
	localparam int PRESCALE_W            = 26;		// Fits a full second

	//----------------------------------------------------------------------
	// Score display
	//----------------------------------------------------------------------

	localparam int BCD_DIGITS = 3;			// Score digits on HEX0..HEX2

	typedef logic [3:0] bcd_digit_t;		// One decimal digit
	typedef logic [6:0] seg7_t;				// Active low, bit 0 = segment a

	localparam seg7_t SEG7_BLANK = 7'b111_1111;	// All segments off

	// Scroll position, tile above pixel
	typedef struct packed {
		logic [TILE_POS_W-1:0]  tile;
		logic [PIXEL_POS_W-1:0] pixel;
	} scroll_pos_t;

	// Push buttons, high when pressed
	typedef struct packed {
		logic right;
		logic left;
	} buttons_t;

	// Frame loop phases
	typedef enum logic [1:0] {
		RENDER,
		MOVE,
		WAIT
	} frame_phase_e;

endpackage

// File: src/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer
#(
	parameter int frame_clocks = game_pkg::FRAME_CLOCKS_DEFAULT	// Frame period in clocks
)
(
	input  logic CLOCK_50,
	input  logic resetn,
	input  logic render_ack,	// From external renderer
	output logic render_req,	// To external renderer
	output logic move_en		// One cycle per frame
);
	import game_pkg::*;

	frame_phase_e             phase;		// Current frame phase
	logic                     ack_seen;		// Renderer acked, waiting for ack low
	logic [FRAME_TIMER_W-1:0] frame_timer;	// Clocks since start of MOVE
	logic                     frame_done;

	// Last cycle of the frame period
	assign frame_done = (frame_timer >= FRAME_TIMER_W'(frame_clocks - 1));

	// Move strobe straight from the phase
	assign move_en = (phase == MOVE);

	//----------------------------------------------------------------------
	// Phase register, handshake and frame timer
	//----------------------------------------------------------------------

	always_ff @(posedge CLOCK_50 or negedge resetn)
	begin
		if (!resetn)
		begin
			phase       <= RENDER;
			render_req  <= 1'b0;
			ack_seen    <= 1'b0;
			frame_timer <= '0;
		end
		else
		begin
			case (phase)
				RENDER:
				begin
					frame_timer <= '0;		// Held clear while drawing
					if (!ack_seen)
					begin
						if (!render_req)
							render_req <= 1'b1;		// Step 1, raise request
						else if (render_ack)
						begin
							render_req <= 1'b0;		// Step 3, drop request
							ack_seen   <= 1'b1;
						end
					end
					else if (!render_ack)	// Step 5, ack gone low
					begin
						ack_seen <= 1'b0;
						phase    <= MOVE;
					end
				end
				MOVE:
				begin
					frame_timer <= frame_timer + 1'b1;	// Timer starts here
					phase       <= WAIT;
				end
				WAIT:
				begin
					if (frame_done)
					begin
						frame_timer <= '0;
						phase       <= RENDER;		// Next frame
					end
					else
						frame_timer <= frame_timer + 1'b1;
				end
				default:
					phase <= RENDER;	// Unused encoding
			endcase
		end
	end

endmodule

// File: src/scroll_counter.sv
`timescale 1ns/1ps

module scroll_counter
(
	input  logic                  CLOCK_50,
	input  logic                  resetn,
	input  logic                  move_en,		// Move strobe from sequencer
	input  game_pkg::buttons_t    buttons,		// Sampled only on move_en
	output game_pkg::scroll_pos_t scroll_pos	// Level position
);
	import game_pkg::*;

	localparam logic [PIXEL_POS_W-1:0] LAST_PIXEL = PIXEL_POS_W'(TILE_PIXELS - 1);

	scroll_pos_t pos_next;
	logic        at_origin;		// Tile 0, pixel 0

	assign at_origin = (scroll_pos.tile == '0) && (scroll_pos.pixel == '0);

	//----------------------------------------------------------------------
	// Next position
	//----------------------------------------------------------------------

	always_comb
	begin
		pos_next = scroll_pos;		// Hold by default
		if (move_en)
		begin
			if (buttons.right)		// Right wins over left
			begin
				pos_next.pixel = scroll_pos.pixel + 1'b1;	// Wraps 7 to 0
				if (scroll_pos.pixel == LAST_PIXEL)
					pos_next.tile = scroll_pos.tile + 1'b1;	// Carry into tile
			end
			else if (buttons.left && !at_origin)	// No scrolling past the start
			begin
				pos_next.pixel = scroll_pos.pixel - 1'b1;	// Wraps 0 to 7
				if (scroll_pos.pixel == '0)
					pos_next.tile = scroll_pos.tile - 1'b1;	// Borrow from tile
			end
		end
	end

	// Position register
	always_ff @(posedge CLOCK_50 or negedge resetn)
	begin
		if (!resetn)
			scroll_pos <= '0;
		else
			scroll_pos <= pos_next;
	end

endmodule

// File: src/score_counter.sv
`timescale 1ns/1ps

module score_counter
#(
	parameter int second_clocks = game_pkg::SECOND_CLOCKS_DEFAULT	// Clocks per score tick
)
(
	input  logic                 CLOCK_50,
	input  logic                 resetn,
	output game_pkg::bcd_digit_t digit0,	// Ones
	output game_pkg::bcd_digit_t digit1,	// Tens
	output game_pkg::bcd_digit_t digit2		// Hundreds
);
	import game_pkg::*;

	logic [PRESCALE_W-1:0] prescale;			// Clocks within the current second
	logic                  second_tick;			// One cycle per second
	bcd_digit_t            digits [BCD_DIGITS];
	logic [BCD_DIGITS-1:0] carry;				// carry[i] steps digit i

	//----------------------------------------------------------------------
	// Seconds prescaler
	//----------------------------------------------------------------------

	assign second_tick = (prescale == PRESCALE_W'(second_clocks - 1));

	always_ff @(posedge CLOCK_50 or negedge resetn)
	begin
		if (!resetn)
			prescale <= '0;
		else if (second_tick)
			prescale <= '0;		// Start next second
		else
			prescale <= prescale + 1'b1;
	end

	//----------------------------------------------------------------------
	// Cascaded decade counters
	//----------------------------------------------------------------------

	assign carry[0] = second_tick;

	for (genvar i = 0; i < BCD_DIGITS; i++)
	begin : g_digit
		// Ripple to next digit when this one rolls over
		if (i < BCD_DIGITS - 1)
		begin : g_carry
			assign carry[i+1] = carry[i] && (digits[i] == 4'd9);
		end

		always_ff @(posedge CLOCK_50 or negedge resetn)
		begin
			if (!resetn)
				digits[i] <= '0;
			else if (carry[i])
			begin
				if (digits[i] == 4'd9)
					digits[i] <= '0;		// 9 wraps to 0, carry out same edge
				else
					digits[i] <= digits[i] + 1'b1;
			end
		end
	end

	// Top digit wraps 999 to 000, nothing above it

	assign digit0 = digits[0];
	assign digit1 = digits[1];
	assign digit2 = digits[2];

endmodule

// File: src/seg7_decoder.sv
`timescale 1ns/1ps

module seg7_decoder
(
	input  game_pkg::bcd_digit_t digit,		// BCD value
	output game_pkg::seg7_t      segments	// Active low, bit 0 = a
);
	import game_pkg::*;

	// Segment order gfedcba, a lit segment is 0
	always_comb
	begin
		case (digit)
			4'd0:    segments = 7'b100_0000;
			4'd1:    segments = 7'b111_1001;
			4'd2:    segments = 7'b010_0100;
			4'd3:    segments = 7'b011_0000;
			4'd4:    segments = 7'b001_1001;
			4'd5:    segments = 7'b001_0010;
			4'd6:    segments = 7'b000_0010;
			4'd7:    segments = 7'b111_1000;
			4'd8:    segments = 7'b000_0000;
			4'd9:    segments = 7'b001_0000;
			default: segments = SEG7_BLANK;		// 10 to 15 dark
		endcase
	end

endmodule

// File: src/game_top.sv
`timescale 1ns/1ps

module game_top
#(
	parameter int frame_clocks  = game_pkg::FRAME_CLOCKS_DEFAULT,	// Frame period
	parameter int second_clocks = game_pkg::SECOND_CLOCKS_DEFAULT	// Score tick period
)
(
	input  logic                  CLOCK_50,
	input  logic                  resetn,
	input  game_pkg::buttons_t    buttons,		// Scroll buttons
	input  logic                  render_ack,	// Renderer handshake
	output logic                  render_req,
	output game_pkg::scroll_pos_t scroll_pos,	// Level position
	output game_pkg::seg7_t       hex0,			// Score ones
	output game_pkg::seg7_t       hex1,			// Score tens
	output game_pkg::seg7_t       hex2			// Score hundreds
);
	import game_pkg::*;

	logic       move_en;	// Single-cycle move strobe
	bcd_digit_t digit0;
	bcd_digit_t digit1;
	bcd_digit_t digit2;

	//----------------------------------------------------------------------
	// Frame loop
	//----------------------------------------------------------------------

	frame_sequencer #(
		.frame_clocks (frame_clocks)
	) sequencer0 (
		.CLOCK_50   (CLOCK_50),
		.resetn     (resetn),
		.render_ack (render_ack),
		.render_req (render_req),
		.move_en    (move_en)
	);

	scroll_counter scroll0 (
		.CLOCK_50   (CLOCK_50),
		.resetn     (resetn),
		.move_en    (move_en),
		.buttons    (buttons),
		.scroll_pos (scroll_pos)
	);

	//----------------------------------------------------------------------
	// Survival score
	//----------------------------------------------------------------------

	score_counter #(
		.second_clocks (second_clocks)
	) score0 (
		.CLOCK_50 (CLOCK_50),
		.resetn   (resetn),
		.digit0   (digit0),
		.digit1   (digit1),
		.digit2   (digit2)
	);

	// One decoder per display
	seg7_decoder seg0 (.digit(digit0), .segments(hex0));
	seg7_decoder seg1 (.digit(digit1), .segments(hex1));
	seg7_decoder seg2 (.digit(digit2), .segments(hex2));

endmodule

// File: tests/game_top_tb.sv
`timescale 1ns/1ps

module game_top_tb;
	import game_pkg::*;

	localparam int FRAME_CLOCKS  = 20;		// Short frames for simulation
	localparam int SECOND_CLOCKS = 6;		// Score tick every 6 clocks
	localparam int RESET_CYCLES  = 5;
	localparam int NUM_FRAMES    = 26;		// Data lines in the pattern file
	localparam int SCORE_CYCLES  = 6100;	// Past the 999 to 000 wrap
	localparam int WAIT_LIMIT    = 100;		// Cycles before a wait gives up
	localparam int EXTRA_LIMIT   = 1000;	// Idle frames after the pattern file

	logic        CLOCK_50;
	logic        resetn;
	buttons_t    buttons;
	logic        render_ack;
	logic        render_req;
	scroll_pos_t scroll_pos;
	seg7_t       hex0;
	seg7_t       hex1;
	seg7_t       hex2;

	logic [15:0] pattern_mem [0:4*NUM_FRAMES-1];	// right, left, tile, pixel
	logic [7:0]  lfsr_state;						// Renderer delay source
	int          cycle_count    = 0;	// Edges since reset release
	logic        prev_req       = 1'b0;
	logic        prev_ack       = 1'b0;
	logic        ack_fell       = 1'b0;	// At least one handshake finished
	int          since_ack_fall = 0;	// Samples since render_ack fell

	game_top #(
		.frame_clocks  (FRAME_CLOCKS),
		.second_clocks (SECOND_CLOCKS)
	) dut0 (
		.CLOCK_50   (CLOCK_50),
		.resetn     (resetn),
		.buttons    (buttons),
		.render_ack (render_ack),
		.render_req (render_req),
		.scroll_pos (scroll_pos),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex2       (hex2)
	);

	// 4 ns clock
	initial
	begin
		CLOCK_50 = 1'b0;
		forever
			#2 CLOCK_50 = ~CLOCK_50;
	end

	//----------------------------------------------------------------------
	// Helpers
	//----------------------------------------------------------------------

	// 8-bit Fibonacci LFSR, taps 8 6 5 4
	function automatic logic [7:0] lfsr_next(input logic [7:0] state);
		logic feedback;
		feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
		return {state[6:0], feedback};
	endfunction

	// Standard digit shapes, returned active low
	function automatic seg7_t seg_pattern(input int value);
		logic [6:0] lit;	// gfedcba, 1 = lit
		case (value)
			0:       lit = 7'h3f;
			1:       lit = 7'h06;
			2:       lit = 7'h5b;
			3:       lit = 7'h4f;
			4:       lit = 7'h66;
			5:       lit = 7'h6d;
			6:       lit = 7'h7d;
			7:       lit = 7'h07;
			8:       lit = 7'h7f;
			9:       lit = 7'h6f;
			default: lit = 7'h00;
		endcase
		return ~lit;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic report_mismatch(input string msg);
		abort_run($sformatf("[FAIL] %0t ns: %s", $time, msg));
	endtask

	// Two LFSR bits give 0 to 3 cycles
	task automatic pick_delay(output int delay);
		delay = 0;
		repeat (2)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			delay = (delay << 1) | lfsr_state[0];
		end
	endtask

	task automatic wait_for_req(input logic level);
		int cycles;
		cycles = 0;
		while (render_req !== level)
		begin
			@(negedge CLOCK_50);
			cycles++;
			assert (cycles <= WAIT_LIMIT)
			else
				abort_run($sformatf("Timed out waiting for render_req to become %0d", level));
		end
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) @(negedge CLOCK_50);
	endtask

	task automatic drive_ack(input logic value);
		@(posedge CLOCK_50);
		render_ack <= value;
		@(negedge CLOCK_50);
	endtask

	// Renderer side of one frame; scroll_pos checked as the request rises
	task automatic run_frame(input int frame, input buttons_t press,
		input scroll_pos_t expected);
		int delay;
		wait_for_req(1'b1);
		assert (scroll_pos === expected)
		else
			report_mismatch($sformatf("frame %0d tile %0d pixel %0d, expected tile %0d pixel %0d",
				frame, scroll_pos.tile, scroll_pos.pixel, expected.tile, expected.pixel));
		@(posedge CLOCK_50);
		buttons <= press;		// Held through this frame's MOVE
		@(negedge CLOCK_50);
		pick_delay(delay);
		idle_cycles(delay);
		drive_ack(1'b1);
		wait_for_req(1'b0);
		pick_delay(delay);
		idle_cycles(delay);
		drive_ack(1'b0);		// MOVE follows once this is seen
	endtask

	//----------------------------------------------------------------------
	// Monitors, sampled on the falling edge
	//----------------------------------------------------------------------

	always @(posedge CLOCK_50)
	begin
		if (resetn)
			cycle_count <= cycle_count + 1;
	end

	task automatic check_score();
		int value;
		value = (cycle_count / SECOND_CLOCKS) % 1000;
		assert (hex0 === seg_pattern(value % 10) && hex1 === seg_pattern((value / 10) % 10)
			&& hex2 === seg_pattern(value / 100))
		else
			report_mismatch($sformatf("after %0d cycles hex2..0 = %h %h %h, expected score %0d",
				cycle_count, hex2, hex1, hex0, value));
	endtask

	task automatic check_handshake();
		if (cycle_count == 0)
			assert (scroll_pos === '0 && render_req === 1'b0)
			else
				report_mismatch("scroll_pos or render_req not cleared after reset");
		if (cycle_count == 1)
			assert (render_req === 1'b1)
			else
				report_mismatch("render_req did not rise on the first edge after reset");
		if (prev_req && !render_req)
			assert (prev_ack)
			else
				report_mismatch("render_req fell before render_ack was high");
		// Sample after ack low, then MOVE plus WAIT, before the request edge
		if (!prev_req && render_req)
			assert (cycle_count == 1 || (ack_fell && !render_ack
				&& since_ack_fall >= FRAME_CLOCKS + 1))
			else
				report_mismatch($sformatf("render_req rose %0d cycles after render_ack fell",
					since_ack_fall));
		if (prev_ack && !render_ack)
		begin
			ack_fell       = 1'b1;
			since_ack_fall = 0;
		end
		else
			since_ack_fall++;
		prev_req = render_req;
		prev_ack = render_ack;
	endtask

	always @(negedge CLOCK_50)
	begin
		if (resetn)
		begin
			check_score();
			check_handshake();
		end
	end

	//----------------------------------------------------------------------
	// Stimulus
	//----------------------------------------------------------------------

	initial
	begin
		scroll_pos_t expected;
		buttons_t    press;
		int          frame;
		resetn     <= 1'b0;
		buttons    <= '0;
		render_ack <= 1'b0;
		lfsr_state = 8'd99;
		$readmemh("tests/scroll_patterns.txt", pattern_mem);
		assert (pattern_mem[4*NUM_FRAMES-1] !== 'x)
		else
			abort_run("Pattern file tests/scroll_patterns.txt is missing or too short");
		repeat (RESET_CYCLES) @(posedge CLOCK_50);
		resetn <= 1'b1;
		@(negedge CLOCK_50);

		expected = '0;
		for (frame = 0; frame < NUM_FRAMES; frame++)
		begin
			press.right = pattern_mem[4*frame][0];
			press.left  = pattern_mem[4*frame+1][0];
			run_frame(frame, press, expected);
			expected.tile  = pattern_mem[4*frame+2];
			expected.pixel = pattern_mem[4*frame+3][PIXEL_POS_W-1:0];
		end

		// Idle frames until the score has wrapped
		press = '0;
		while (cycle_count < SCORE_CYCLES)
		begin
			assert (frame < NUM_FRAMES + EXTRA_LIMIT)
			else
				abort_run("Too many idle frames before the score run finished");
			run_frame(frame, press, expected);
			frame++;
		end
		wait_for_req(1'b1);
		assert (scroll_pos === expected)
		else
			report_mismatch("scroll_pos moved during idle frames");

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: tests/scroll_patterns.txt
// Columns: right left tile pixel, hex, one line per frame
// tile and pixel are the position expected after that frame's move
0 1 0000 0
1 0 0000 1
1 0 0000 2
1 0 0000 3
1 0 0000 4
1 0 0000 5
1 0 0000 6
1 0 0000 7
1 0 0001 0
1 0 0001 1
1 1 0001 2
0 0 0001 2
0 1 0001 1
0 1 0001 0
0 1 0000 7
0 1 0000 6
1 1 0000 7
0 1 0000 6
0 1 0000 5
0 1 0000 4
0 1 0000 3
0 1 0000 2
0 1 0000 1
0 1 0000 0
0 1 0000 0
1 1 0000 1

// File: project.f
src/game_pkg.sv
src/frame_sequencer.sv
src/scroll_counter.sv
src/score_counter.sv
src/seg7_decoder.sv
src/game_top.sv
tests/game_top_tb.sv
